// ==== design/oob_host_fsm.sv ====
`timescale 1ns/1ps

`include "sata_oob_cfg.svh"

module oob_host_fsm (
    input  logic                       sys_clk,
    input  logic                       sys_rst,
    input  sata_oob_pkg::sata_gen_t    gen_i,
    input  logic                       test_port_i,         // Force a bring-up
    input  logic                       phy_reset_done_i,
    input  logic                       tx_comfinish_i,      // PHY burst finished
    input  logic                       cominit_done_i,      // From tx driver
    input  logic                       comwake_done_i,
    oob_rx_if.dst                      rx,
    output sata_oob_pkg::oob_state_e   next_state_o
);

    sata_oob_pkg::oob_state_e state;
    sata_oob_pkg::oob_state_e next_state;

    logic                   oob_start;      // Registered start request
    sata_oob_pkg::oob_tmr_t quiet_cnt;
    sata_oob_pkg::oob_tmr_t align_cnt;
    sata_oob_pkg::oob_tmr_t retry_cnt;
    sata_oob_pkg::oob_tmr_t align_lim;
    sata_oob_pkg::oob_tmr_t retry_lim;
    logic                   quiet_done;
    logic                   align_tmo;
    logic                   retry_tmo;

    // Timeouts follow the line rate
    assign align_lim = sata_oob_pkg::oob_scale(`OOB_GEN1_ALIGN_TMO, gen_i);
    assign retry_lim = sata_oob_pkg::oob_scale(`OOB_GEN1_RETRY_TMO, gen_i);

    assign quiet_done = (quiet_cnt == `OOB_QUIET_CNT);
    assign align_tmo  = (align_cnt == align_lim);
    assign retry_tmo  = (retry_cnt == retry_lim);

    assign next_state_o = next_state;   // Tx driver registers from this

    //////////////////////////////////////////////////////////////////////
    // Start qualification
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            oob_start <= 1'b0;
        end else begin
            // Blocked once the link is up
            oob_start <= (test_port_i || rx.cominit) && phy_reset_done_i &&
                         (state != sata_oob_pkg::LINK_READY);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state <= sata_oob_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state; // Hold unless a condition fires
        case (state)
            sata_oob_pkg::IDLE: begin
                if (oob_start) begin
                    next_state = sata_oob_pkg::COMINIT;
                end
            end
            sata_oob_pkg::COMINIT: begin
                if (cominit_done_i && tx_comfinish_i) begin
                    next_state = sata_oob_pkg::WAIT_COMWAKE;
                end
            end
            sata_oob_pkg::WAIT_COMWAKE: begin
                if (rx.comwake) begin
                    next_state = sata_oob_pkg::WAIT_NO_COMWAKE;
                end else if (retry_tmo) begin
                    next_state = sata_oob_pkg::IDLE;    // Retry from scratch
                end
            end
            sata_oob_pkg::WAIT_NO_COMWAKE: begin
                if (quiet_done) begin
                    next_state = sata_oob_pkg::CALIBRATE;
                end
            end
            sata_oob_pkg::CALIBRATE: begin
                next_state = sata_oob_pkg::COMWAKE;     // Single cycle
            end
            sata_oob_pkg::COMWAKE: begin
                if (comwake_done_i && tx_comfinish_i) begin
                    next_state = sata_oob_pkg::SEND_ALIGN;
                end
            end
            sata_oob_pkg::SEND_ALIGN: begin
                if (rx.align_seen) begin
                    next_state = sata_oob_pkg::LINK_READY;
                end else if (align_tmo) begin
                    next_state = sata_oob_pkg::IDLE;
                end
            end
            sata_oob_pkg::LINK_READY: begin
                if (rx.elecidle) begin
                    next_state = sata_oob_pkg::IDLE;    // Link lost
                end
            end
            default: next_state = sata_oob_pkg::IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    // Counts quiet cycles after the device COMWAKE, saturates at the limit
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            quiet_cnt <= '0;
        end else if (state != sata_oob_pkg::WAIT_NO_COMWAKE || rx.comwake) begin
            quiet_cnt <= '0;
        end else if (!quiet_done) begin
            quiet_cnt <= quiet_cnt + 1'b1;
        end
    end

    // 55 us ALIGN wait
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            align_cnt <= '0;
        end else if (state == sata_oob_pkg::SEND_ALIGN) begin
            align_cnt <= align_cnt + 1'b1;
        end else begin
            align_cnt <= '0;
        end
    end

    // 880 us device COMWAKE wait
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            retry_cnt <= '0;
        end else if (state == sata_oob_pkg::WAIT_COMWAKE) begin
            retry_cnt <= retry_cnt + 1'b1;
        end else begin
            retry_cnt <= '0;
        end
    end

endmodule

// ==== design/oob_rx_detect.sv ====
`timescale 1ns/1ps

`include "sata_oob_cfg.svh"

module oob_rx_detect (
    input  logic                 sys_clk,
    input  logic                 sys_rst,

    // PHY OOB status
    input  logic                 rx_cominit_i,
    input  logic                 rx_comwake_i,
    input  logic                 rx_elecidle_i,

    // Rx data from the transceiver
    input  sata_oob_pkg::dword_t rx_data_i,
    input  sata_oob_pkg::kmask_t rx_charisk_i,

    oob_rx_if.src                rx
);

    logic align_match;  // Word and K flags both match

    assign align_match = (rx_data_i == `OOB_ALIGN_PRIM) &&
                         (rx_charisk_i == `OOB_PRIM_KMASK);

    //////////////////////////////////////////////////////////////////////
    // OOB flag registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            rx.cominit  <= 1'b0;
            rx.comwake  <= 1'b0;
            rx.elecidle <= 1'b0;
        end else begin
            rx.cominit  <= rx_cominit_i;    // One cycle late
            rx.comwake  <= rx_comwake_i;
            rx.elecidle <= rx_elecidle_i;
        end
    end

    // ALIGN detect, same latency as the flags
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            rx.align_seen <= 1'b0;
        end else begin
            rx.align_seen <= align_match;
        end
    end

endmodule

// ==== design/oob_rx_if.sv ====
`timescale 1ns/1ps

// Registered receive side OOB events
interface oob_rx_if;

    logic cominit;      // Device COMINIT seen
    logic comwake;      // Device COMWAKE seen
    logic elecidle;     // Rx line idle
    logic align_seen;   // ALIGN primitive received

    // Driven by the receive detector
    modport src (
        output cominit, comwake, elecidle, align_seen
    );

    // Read by the sequencer
    modport dst (
        input cominit, comwake, elecidle, align_seen
    );

endinterface

// ==== design/oob_tx_driver.sv ====
`timescale 1ns/1ps

`include "sata_oob_cfg.svh"

module oob_tx_driver (
    input  logic                       sys_clk,
    input  logic                       sys_rst,
    input  sata_oob_pkg::sata_gen_t    gen_i,
    input  sata_oob_pkg::oob_state_e   next_state_i,

    // PHY OOB controls
    output logic                       tx_cominit_o,
    output logic                       tx_comwake_o,
    output logic                       tx_elecidle_o,
    output logic                       rx_cdrhold_o,

    // Tx primitives
    output sata_oob_pkg::dword_t       tx_data_o,
    output sata_oob_pkg::kmask_t       tx_charisk_o,

    output logic                       link_up_o,
    output logic                       cominit_done_o,  // Burst count reached
    output logic                       comwake_done_o
);

    sata_oob_pkg::oob_tmr_t burst_cnt;      // Shared by both bursts
    sata_oob_pkg::oob_tmr_t cdr_cnt;
    sata_oob_pkg::oob_tmr_t comreset_lim;
    sata_oob_pkg::oob_tmr_t comwake_lim;
    sata_oob_pkg::oob_tmr_t cdr_lim;
    logic                   linked;         // Transmitter active

    assign comreset_lim = sata_oob_pkg::oob_scale(`OOB_GEN1_COMRESET, gen_i);
    assign comwake_lim  = sata_oob_pkg::oob_scale(`OOB_GEN1_COMWAKE, gen_i);
    assign cdr_lim      = sata_oob_pkg::oob_scale(`OOB_GEN1_CDRHOLD, gen_i);

    assign linked = (next_state_i == sata_oob_pkg::SEND_ALIGN) ||
                    (next_state_i == sata_oob_pkg::LINK_READY);

    //////////////////////////////////////////////////////////////////////
    // COMRESET / COMWAKE bursts
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            burst_cnt      <= '0;
            tx_cominit_o   <= 1'b0;
            tx_comwake_o   <= 1'b0;
            cominit_done_o <= 1'b0;
            comwake_done_o <= 1'b0;
        end else begin
            tx_cominit_o   <= 1'b0;
            tx_comwake_o   <= 1'b0;
            cominit_done_o <= 1'b0;
            comwake_done_o <= 1'b0;
            case (next_state_i)
                sata_oob_pkg::COMINIT: begin
                    if (burst_cnt == comreset_lim) begin
                        cominit_done_o <= 1'b1;     // Hold until the state moves on
                    end else begin
                        tx_cominit_o <= 1'b1;
                        burst_cnt    <= burst_cnt + 1'b1;
                    end
                end
                sata_oob_pkg::COMWAKE: begin
                    if (burst_cnt == comwake_lim) begin
                        comwake_done_o <= 1'b1;
                    end else begin
                        tx_comwake_o <= 1'b1;
                        burst_cnt    <= burst_cnt + 1'b1;
                    end
                end
                default: burst_cnt <= '0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Line state, CDR hold and link up
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            tx_elecidle_o <= 1'b1;
            rx_cdrhold_o  <= 1'b1;
            cdr_cnt       <= '0;
            link_up_o     <= 1'b0;
        end else begin
            tx_elecidle_o <= !linked;
            link_up_o     <= (next_state_i == sata_oob_pkg::LINK_READY);
            if (!linked) begin
                rx_cdrhold_o <= 1'b1;               // Hold CDR while idle
                cdr_cnt      <= '0;
            end else if (cdr_cnt == cdr_lim) begin
                rx_cdrhold_o <= 1'b0;
            end else begin
                rx_cdrhold_o <= 1'b1;
                cdr_cnt      <= cdr_cnt + 1'b1;
            end
        end
    end

    // Primitive select
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            tx_data_o    <= '0;
            tx_charisk_o <= '0;
        end else begin
            case (next_state_i)
                sata_oob_pkg::SEND_ALIGN: begin
                    tx_data_o    <= `OOB_ALIGN_PRIM;
                    tx_charisk_o <= `OOB_PRIM_KMASK;
                end
                sata_oob_pkg::LINK_READY: begin
                    tx_data_o    <= `OOB_RRDY_PRIM;
                    tx_charisk_o <= `OOB_PRIM_KMASK;
                end
                default: begin
                    tx_data_o    <= '0;
                    tx_charisk_o <= '0;
                end
            endcase
        end
    end

endmodule

// ==== design/sata_oob_host.sv ====
`timescale 1ns/1ps

module sata_oob_host (
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  sata_oob_pkg::sata_gen_t  gen_i,             // SATA generation 1 to 3
    input  logic                     test_port_i,
    input  logic                     phy_reset_done_i,

    // Rx side of the transceiver
    input  logic                     rx_cominit_i,
    input  logic                     rx_comwake_i,
    input  logic                     rx_elecidle_i,
    input  sata_oob_pkg::dword_t     rx_data_i,
    input  sata_oob_pkg::kmask_t     rx_charisk_i,
    output logic                     rx_cdrhold_o,

    // Tx side of the transceiver
    input  logic                     tx_comfinish_i,
    output logic                     tx_cominit_o,
    output logic                     tx_comwake_o,
    output logic                     tx_elecidle_o,
    output sata_oob_pkg::dword_t     tx_data_o,
    output sata_oob_pkg::kmask_t     tx_charisk_o,

    output logic                     link_up_o
);

    sata_oob_pkg::oob_state_e next_state;   // Sequencer to tx driver
    logic                     cominit_done;
    logic                     comwake_done;

    oob_rx_if rx_if ();

    // Input side
    oob_rx_detect u_rx_detect (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .rx_cominit_i  (rx_cominit_i),
        .rx_comwake_i  (rx_comwake_i),
        .rx_elecidle_i (rx_elecidle_i),
        .rx_data_i     (rx_data_i),
        .rx_charisk_i  (rx_charisk_i),
        .rx            (rx_if.src)
    );

    oob_host_fsm u_host_fsm (
        .sys_clk          (sys_clk),
        .sys_rst          (sys_rst),
        .gen_i            (gen_i),
        .test_port_i      (test_port_i),
        .phy_reset_done_i (phy_reset_done_i),
        .tx_comfinish_i   (tx_comfinish_i),
        .cominit_done_i   (cominit_done),
        .comwake_done_i   (comwake_done),
        .rx               (rx_if.dst),
        .next_state_o     (next_state)
    );

    // Output side, all registered
    oob_tx_driver u_tx_driver (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .gen_i          (gen_i),
        .next_state_i   (next_state),
        .tx_cominit_o   (tx_cominit_o),
        .tx_comwake_o   (tx_comwake_o),
        .tx_elecidle_o  (tx_elecidle_o),
        .rx_cdrhold_o   (rx_cdrhold_o),
        .tx_data_o      (tx_data_o),
        .tx_charisk_o   (tx_charisk_o),
        .link_up_o      (link_up_o),
        .cominit_done_o (cominit_done),
        .comwake_done_o (comwake_done)
    );

endmodule

// ==== design/sata_oob_pkg.sv ====
package sata_oob_pkg;

`include "sata_oob_cfg.svh"

    // Host OOB sequencer states
    typedef enum logic [3:0] {
        IDLE,
        COMINIT,            // Sending COMRESET
        WAIT_COMWAKE,
        WAIT_NO_COMWAKE,    // Device COMWAKE must go quiet
        CALIBRATE,
        COMWAKE,            // Sending host COMWAKE
        SEND_ALIGN,
        LINK_READY
    } oob_state_e;

    typedef logic [1:0]            sata_gen_t;  // 1 to 3
    typedef logic [31:0]           dword_t;
    typedef logic [3:0]            kmask_t;
    typedef logic [`OOB_TMR_W-1:0] oob_tmr_t;

    // Gen1 count scaled to the line rate, gen 0 taken as gen 1
    function automatic oob_tmr_t oob_scale(input oob_tmr_t base, input sata_gen_t gen);
        sata_gen_t shift;
        shift = (gen == 2'd0) ? 2'd0 : gen - 2'd1;
        return base << shift;
    endfunction

endpackage

// ==== include/sata_oob_cfg.svh ====
`ifndef SATA_OOB_CFG_SVH
`define SATA_OOB_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Primitive codes
//////////////////////////////////////////////////////////////////////

// K28.5 D10.2 D10.2 D27.3
`define OOB_ALIGN_PRIM      32'h7B4A_4ABC

// K28.3 D21.4 D10.2 D10.2
`define OOB_RRDY_PRIM       32'h4A4A_957C

// Only the lowest byte is a K character
`define OOB_PRIM_KMASK      4'b0001

//////////////////////////////////////////////////////////////////////
// Gen1 cycle counts at 37.5 MHz that double per generation
//////////////////////////////////////////////////////////////////////

`define OOB_GEN1_COMRESET   155     // COMRESET burst, about 4.1 us

`define OOB_GEN1_COMWAKE    49      // COMWAKE burst, about 1.3 us

// CDR settle time after ALIGN starts, above 250 ns
`define OOB_GEN1_CDRHOLD    20

`define OOB_GEN1_ALIGN_TMO  2063    // 55 us without ALIGN back
`define OOB_GEN1_RETRY_TMO  33000   // 880 us without device COMWAKE

// Quiet cycles on rx COMWAKE before calibrating
`define OOB_QUIET_CNT       16

// Wide enough for 33000 << 2
`define OOB_TMR_W           20

`endif

// ==== verification/oob_patterns.txt ====
// Columns in hex: generation, scenario code, COMRESET length, COMWAKE length
// Codes: 1 bring-up, 2 no device COMWAKE, 3 no device ALIGN, 4 link loss
// Full bring-up at gen 1, 2 and 3
1 1 009B 0031
2 1 0136 0062
3 1 026C 00C4
// Retry timeout, no COMWAKE column
1 2 009B 0000
// ALIGN timeout
1 3 009B 0031
// Electrical idle while linked
1 4 009B 0031
3 4 026C 00C4
// End marker
0 0 0000 0000

// ==== verification/sata_oob_host_sva.sv ====
`timescale 1ns/1ps

module sata_oob_host_sva (
    input logic sys_clk,
    input logic sys_rst,
    input logic tx_cominit_o,
    input logic tx_comwake_o,
    input logic tx_elecidle_o,
    input logic rx_cdrhold_o,
    input logic link_up_o
);

    int fail_cnt = 0;   // Failed assertion count

    // One OOB burst on the line at a time
    a_one_burst: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(tx_cominit_o && tx_comwake_o))
    else begin
        fail_cnt++;
        $error("COMRESET and COMWAKE bursts overlap");
    end

    a_link_active: assert property (@(posedge sys_clk) disable iff (sys_rst)
        link_up_o |-> !tx_elecidle_o)   // Linked means transmitting
    else begin
        fail_cnt++;
        $error("Link up while tx electrical idle");
    end

    // CDR held while the line is idle
    a_cdr_hold_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
        tx_elecidle_o |-> rx_cdrhold_o)
    else begin
        fail_cnt++;
        $error("CDR hold released during electrical idle");
    end

endmodule

bind sata_oob_host sata_oob_host_sva u_sva (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .tx_cominit_o  (tx_cominit_o),
    .tx_comwake_o  (tx_comwake_o),
    .tx_elecidle_o (tx_elecidle_o),
    .rx_cdrhold_o  (rx_cdrhold_o),
    .link_up_o     (link_up_o)
);

// ==== verification/tb_sata_oob_host.sv ====
`timescale 1ns/1ps

`include "sata_oob_cfg.svh"

module tb_sata_oob_host;

    localparam int PAT_WORDS = 32;  // 8 lines of 4 words
    localparam int MARGIN    = 32;  // Slack on timeout latencies

    logic                    sys_clk;
    logic                    sys_rst          = 1'b1;
    sata_oob_pkg::sata_gen_t gen_i            = 2'd1;
    logic                    test_port_i      = 1'b0;
    logic                    phy_reset_done_i = 1'b0;
    logic                    rx_cominit_i     = 1'b0;
    logic                    rx_comwake_i     = 1'b0;
    logic                    rx_elecidle_i    = 1'b0;
    sata_oob_pkg::dword_t    rx_data_i        = '0;
    sata_oob_pkg::kmask_t    rx_charisk_i     = '0;
    logic                    tx_comfinish_i   = 1'b0;
    logic                    rx_cdrhold_o;
    logic                    tx_cominit_o;
    logic                    tx_comwake_o;
    logic                    tx_elecidle_o;
    sata_oob_pkg::dword_t    tx_data_o;
    sata_oob_pkg::kmask_t    tx_charisk_o;
    logic                    link_up_o;

    logic [15:0] pat_mem [0:PAT_WORDS-1];   // gen, code, COMRESET, COMWAKE
    logic        burst_seen = 1'b0;         // PHY has sent a burst
    integer      seed       = 90;
    int          n_checks   = 0;
    int          n_errors   = 0;
    int          n_timeouts = 0;

    sata_oob_host u_sata_oob_host (
        .sys_clk          (sys_clk),
        .sys_rst          (sys_rst),
        .gen_i            (gen_i),
        .test_port_i      (test_port_i),
        .phy_reset_done_i (phy_reset_done_i),
        .rx_cominit_i     (rx_cominit_i),
        .rx_comwake_i     (rx_comwake_i),
        .rx_elecidle_i    (rx_elecidle_i),
        .rx_data_i        (rx_data_i),
        .rx_charisk_i     (rx_charisk_i),
        .rx_cdrhold_o     (rx_cdrhold_o),
        .tx_comfinish_i   (tx_comfinish_i),
        .tx_cominit_o     (tx_cominit_o),
        .tx_comwake_o     (tx_comwake_o),
        .tx_elecidle_o    (tx_elecidle_o),
        .tx_data_o        (tx_data_o),
        .tx_charisk_o     (tx_charisk_o),
        .link_up_o        (link_up_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;     // 40 ns period
    end

    // PHY model raises comfinish once a burst ends and holds it until the next one
    always @(negedge sys_clk) begin
        if (sys_rst) begin
            burst_seen     <= 1'b0;
            tx_comfinish_i <= 1'b0;
        end else if (tx_cominit_o || tx_comwake_o) begin
            burst_seen     <= 1'b1;
            tx_comfinish_i <= 1'b0;
        end else if (burst_seen) begin
            tx_comfinish_i <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_dword(input string what, input sata_oob_pkg::dword_t got,
                               input sata_oob_pkg::dword_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_kmask(input string what, input sata_oob_pkg::kmask_t got,
                               input sata_oob_pkg::kmask_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Inclusive range where lo == hi asks for an exact count
    task automatic check_count(input string what, input int got, input int lo, input int hi);
        n_checks++;
        if (got < lo || got > hi) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d to %0d",
                     $time, what, got, lo, hi);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeouts++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Gen1 count doubled per generation step
    function automatic int scaled_count(input int base, input sata_oob_pkg::sata_gen_t gen);
        return base << (gen - 1);
    endfunction

    function automatic logic burst_level(input bit wake);
        return wake ? tx_comwake_o : tx_cominit_o;
    endfunction

    task automatic apply_reset();
        @(negedge sys_clk);
        sys_rst          = 1'b1;
        test_port_i      = 1'b0;
        phy_reset_done_i = 1'b0;
        rx_cominit_i     = 1'b0;
        rx_comwake_i     = 1'b0;
        rx_elecidle_i    = 1'b0;
        rx_data_i        = '0;
        rx_charisk_i     = '0;
        repeat (10) @(negedge sys_clk);
        sys_rst = 1'b0;
        @(negedge sys_clk);
    endtask

    task automatic check_reset_values();
        check_bit("reset tx_cominit_o", tx_cominit_o, 1'b0);
        check_bit("reset tx_comwake_o", tx_comwake_o, 1'b0);
        check_bit("reset tx_elecidle_o", tx_elecidle_o, 1'b1);
        check_bit("reset rx_cdrhold_o", rx_cdrhold_o, 1'b1);
        check_bit("reset link_up_o", link_up_o, 1'b0);
        check_dword("reset tx_data_o", tx_data_o, '0);
        check_kmask("reset tx_charisk_o", tx_charisk_o, '0);
    endtask

    // Counts lead cycles until the burst rises and then its high time up to the first low sample
    task automatic measure_burst(input bit wake, input int limit,
                                 output int lead, output int len);
        lead = 0;
        len  = 0;
        while (burst_level(wake) !== 1'b1 && lead < limit) begin
            @(negedge sys_clk);
            lead++;
        end
        if (burst_level(wake) !== 1'b1) begin
            report_timeout(wake ? "host COMWAKE to start" : "host COMRESET to start");
        end else begin
            while (burst_level(wake) === 1'b1 && len < limit) begin
                @(negedge sys_clk);
                len++;
            end
            if (burst_level(wake) === 1'b1) begin
                report_timeout(wake ? "host COMWAKE to end" : "host COMRESET to end");
            end
        end
    endtask

    task automatic device_gap();
        int gap;
        gap = ($random(seed) & 15) + 4;
        repeat (gap) @(negedge sys_clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Scenario codes are 1 bring-up, 2 no COMWAKE, 3 no ALIGN and 4 link loss
    //////////////////////////////////////////////////////////////////////

    task automatic run_scenario(input sata_oob_pkg::sata_gen_t gen, input int code,
                                input int exp_reset, input int exp_wake);
        int   lead;
        int   len;
        int   n;
        int   n_cdr;
        logic link_seen;
        if (code < 1 || code > 4) begin
            n_errors++;
            $display("Unknown scenario code %0d in the pattern file", code);
            return;
        end
        gen_i = gen;
        apply_reset();
        check_reset_values();
        if (code == 1) begin
            // Device COMINIT starts the bring-up
            phy_reset_done_i = 1'b1;
            rx_cominit_i     = 1'b1;
            repeat (2) @(negedge sys_clk);
            rx_cominit_i     = 1'b0;
        end else begin
            test_port_i = 1'b1;     // Held so that timeouts restart
            repeat (4) begin
                @(negedge sys_clk);
                check_bit("COMRESET before PHY reset done", tx_cominit_o, 1'b0);
            end
            phy_reset_done_i = 1'b1;
        end
        measure_burst(1'b0, exp_reset + 64, lead, len);
        check_count("COMRESET length", len, exp_reset, exp_reset);
        if (code == 2) begin
            n = scaled_count(`OOB_GEN1_RETRY_TMO, gen);
            measure_burst(1'b0, n + MARGIN, lead, len);
            check_count("retry COMRESET latency", lead, n, n + MARGIN);
            check_count("retry COMRESET length", len, exp_reset, exp_reset);
            return;
        end
        // Device COMWAKE answer
        device_gap();
        rx_comwake_i = 1'b1;
        repeat (10) @(negedge sys_clk);
        rx_comwake_i = 1'b0;
        measure_burst(1'b1, 256, lead, len);
        check_count("COMWAKE length", len, exp_wake, exp_wake);
        n = 0;
        while (tx_data_o === '0 && n < 64) begin
            @(negedge sys_clk);
            n++;
        end
        if (tx_data_o === '0) report_timeout("ALIGN on tx data");
        check_dword("ALIGN data", tx_data_o, `OOB_ALIGN_PRIM);
        check_kmask("ALIGN K mask", tx_charisk_o, `OOB_PRIM_KMASK);
        check_bit("tx electrical idle in ALIGN", tx_elecidle_o, 1'b0);
        n_cdr = 0;
        while (rx_cdrhold_o === 1'b1 && n_cdr < 256) begin
            @(negedge sys_clk);
            n_cdr++;
        end
        if (rx_cdrhold_o === 1'b1) report_timeout("CDR hold release");
        n = scaled_count(`OOB_GEN1_CDRHOLD, gen);
        check_count("CDR hold cycles", n_cdr, n, n);
        if (code == 3) begin
            n         = 0;
            link_seen = 1'b0;
            lead      = scaled_count(`OOB_GEN1_ALIGN_TMO, gen);
            while (tx_cominit_o !== 1'b1 && n < lead + MARGIN) begin
                @(negedge sys_clk);
                n++;
                link_seen = link_seen | link_up_o;
            end
            if (tx_cominit_o !== 1'b1) report_timeout("COMRESET after ALIGN timeout");
            check_count("ALIGN timeout latency", n + n_cdr, lead, lead + MARGIN);
            check_bit("link up without ALIGN", link_seen, 1'b0);
            return;
        end
        device_gap();
        rx_data_i    = `OOB_ALIGN_PRIM;   // Device ALIGN back
        rx_charisk_i = `OOB_PRIM_KMASK;
        n = 0;
        while (link_up_o !== 1'b1 && n < 64) begin
            @(negedge sys_clk);
            n++;
        end
        if (link_up_o !== 1'b1) report_timeout("link up");
        check_dword("R_RDY data", tx_data_o, `OOB_RRDY_PRIM);
        check_kmask("R_RDY K mask", tx_charisk_o, `OOB_PRIM_KMASK);
        check_bit("tx electrical idle when linked", tx_elecidle_o, 1'b0);
        if (code == 4) begin
            rx_elecidle_i = 1'b1;
            n = 0;
            while (link_up_o !== 1'b0 && n < 64) begin
                @(negedge sys_clk);
                n++;
            end
            if (link_up_o !== 1'b0) report_timeout("link down");
            check_bit("tx electrical idle after loss", tx_elecidle_o, 1'b1);
            check_bit("CDR hold after loss", rx_cdrhold_o, 1'b1);
            check_dword("tx data after loss", tx_data_o, '0);
            check_kmask("tx K mask after loss", tx_charisk_o, '0);
        end
    endtask

    initial begin
        int line;
        $readmemh("verification/oob_patterns.txt", pat_mem);
        if (pat_mem[0] === 16'hxxxx) begin
            n_errors++;
            $display("The pattern file could not be read");
        end else begin
            line = 0;
            while (line < PAT_WORDS / 4 && pat_mem[4 * line] != 16'd0) begin
                run_scenario(pat_mem[4 * line][1:0], pat_mem[4 * line + 1],
                             pat_mem[4 * line + 2], pat_mem[4 * line + 3]);
                line++;
            end
        end
        repeat (4) @(negedge sys_clk);
        n_errors += u_sata_oob_host.u_sva.fail_cnt;     // Assertion failures
        $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
design/sata_oob_pkg.sv
design/oob_rx_if.sv
design/oob_rx_detect.sv
design/oob_host_fsm.sv
design/oob_tx_driver.sv
design/sata_oob_host.sv
verification/sata_oob_host_sva.sv
verification/tb_sata_oob_host.sv
